// ==== dv/imem_model.sv ====
module imem_model (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  fetch_pkg::pc_t             addr,
    output logic [fetch_pkg::xlen-1:0] rdata,
    output logic                       done,
    output logic                       due      // Reply goes out on the next edge
);

    import fetch_pkg::*;

    logic [1:0] wait_cnt;   // Cycles left before the reply, drawn while idle

    function automatic logic [xlen-1:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // Program table of jal words, addi-type fill everywhere else
    function automatic logic [xlen-1:0] word_at(input pc_t a);
        logic [xlen-1:0] w;
        case (a)
            32'h8000_0010: w = enc_jal(5'd1, 21'h00_0020);
            32'h8000_0030: w = enc_jal(5'd0, 21'h1F_FFD4);   // Back by 44 bytes
            32'h8000_0200: w = enc_jal(5'd5, 21'h00_1000);
            32'h8000_0400: w = enc_jal(5'd0, 21'h1F_F800);
            default:       w = {a[31:7] ^ a[24:0], 7'b001_0011};
        endcase
        return w;
    endfunction

    assign due = req & ~done & (wait_cnt == 2'd0);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= 2'd0;
            done     <= 1'b0;
            rdata    <= '0;
        end else begin
            done <= 1'b0;
            if (!req || done) begin
                wait_cnt <= 2'($urandom_range(3, 0));   // Latency of 1 to 4 cycles
            end else if (wait_cnt == 2'd0) begin
                done  <= 1'b1;
                rdata <= word_at(addr);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// ==== dv/tb_fetch_top.sv ====
module tb_fetch_top;

    import fetch_pkg::*;

    localparam int  clk_period      = 8;
    localparam int  free_fetches    = 12;
    localparam int  hold_rounds     = 40;
    localparam int  round_fetches   = 2;
    localparam int  planned_fetches = free_fetches + hold_rounds * round_fetches;
    localparam pc_t jal_entry       = 32'h8000_0200;   // Table slot holding a jal

    logic            clk;
    logic            rst_n;
    hold_req_t       hold;
    logic            imem_req;
    pc_t             imem_addr;
    logic [xlen-1:0] imem_rdata;
    logic            imem_done;
    fetch_out_t      fo;
    logic            hold_active;
    logic            mem_due;

    int errors = 0;
    int fetch_count = 0;

    pc_t  model_pc;
    logic model_en;
    logic model_jalr_q;
    logic higher_hold;      // Wait, memory hazard or jalr this cycle
    logic model_hold;
    logic is_jal;
    pc_t  jal_target;

    fetch_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .imem_done   (imem_done),
        .fo          (fo),
        .hold_active (hold_active)
    );

    imem_model u_imem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (imem_req),
        .addr  (imem_addr),
        .rdata (imem_rdata),
        .done  (imem_done),
        .due   (mem_due)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic pc_t jal_offset(input logic [xlen-1:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // Next fetch address by the fixed priority list
    function automatic pc_t predict_pc(input pc_t cur, input hold_req_t h, input logic jalr_last,
                                       input logic done, input logic [xlen-1:0] w);
        logic frozen;
        logic loading;
        if (h.mul_wait) begin
            frozen = !h.mul_done;
        end else if (h.div_wait) begin
            frozen = !h.div_done;
        end else begin
            frozen = h.mem_hold | h.jalr;
        end
        loading = !(h.mul_wait | h.div_wait | h.mem_hold | h.jalr) & (jalr_last | h.redirect);
        if (frozen) begin
            return cur;
        end
        if (loading) begin
            return h.target;
        end
        if (done && w[6:0] == op_jal) begin
            return cur + jal_offset(w);
        end
        return cur + 32'd4;
    endfunction

    always_comb begin
        higher_hold = hold.mul_wait | hold.div_wait | hold.mem_hold | hold.jalr;
        model_hold  = higher_hold | model_jalr_q | hold.redirect;
        is_jal      = (imem_rdata[6:0] == op_jal);
        jal_target  = model_pc + jal_offset(imem_rdata);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_pc     <= reset_pc;
            model_en     <= 1'b0;
            model_jalr_q <= 1'b0;
        end else begin
            model_en     <= 1'b1;
            model_jalr_q <= hold.jalr;
            if (imem_done || model_hold) begin
                model_pc <= predict_pc(model_pc, hold, model_jalr_q, imem_done, imem_rdata);
            end
        end
    end

    always @(posedge clk) begin
        if (fo.valid) begin
            fetch_count <= fetch_count + 1;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    addr_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr == model_pc) else log_error("fetch address differs from next-PC model");
    req_level: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req == (model_en && !model_hold)) else log_error("imem_req level wrong");
    hold_flag: assert property (@(posedge clk) disable iff (!rst_n)
        hold_active == model_hold) else log_error("hold_active wrong");
    valid_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        imem_done |=> fo.valid && fo.pc == $past(imem_addr) && fo.instr == $past(imem_rdata))
        else log_error("fo not valid with captured word one cycle after imem_done");
    valid_only_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        fo.valid |-> $past(imem_done)) else log_error("fo.valid without imem_done");
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_done |=> $stable(imem_addr))
        else log_error("imem_addr moved during a pending request");
    mul_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        hold.mul_wait && !hold.mul_done |=> $stable(imem_addr))
        else log_error("PC moved during multiply wait");
    div_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        !hold.mul_wait && hold.div_wait && !hold.div_done |=> $stable(imem_addr))
        else log_error("PC moved during divide wait");
    wait_step: assert property (@(posedge clk) disable iff (!rst_n)
        ((hold.mul_wait && hold.mul_done) || (!hold.mul_wait && hold.div_wait && hold.div_done))
        && !(imem_done && is_jal) |=> imem_addr == $past(model_pc) + 32'd4)
        else log_error("PC did not step by 4 after wait done");
    mem_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        hold.mem_hold |-> !imem_req && hold_active) else log_error("request during mem_hold");
    mem_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        hold.mem_hold && !hold.mul_wait && !hold.div_wait |=> $stable(imem_addr))
        else log_error("PC moved during mem_hold");
    jalr_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        hold.jalr && !hold.mul_wait && !hold.div_wait && !hold.mem_hold |=> $stable(imem_addr))
        else log_error("PC moved in jalr cycle");
    jalr_load: assert property (@(posedge clk) disable iff (!rst_n)
        model_jalr_q && !higher_hold |=> imem_addr == $past(hold.target))
        else log_error("jalr target not loaded");
    redirect_load: assert property (@(posedge clk) disable iff (!rst_n)
        hold.redirect && !higher_hold |=> imem_addr == $past(hold.target))
        else log_error("redirect target not loaded");
    jal_predict: assert property (@(posedge clk) disable iff (!rst_n)
        imem_done && is_jal && !model_hold |=> imem_addr == $past(jal_target))
        else log_error("jal target not predicted");

    task automatic wait_fetches(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (fo.valid) begin
                seen++;
            end
        end
    endtask

    function automatic pc_t random_target();
        pc_t t;
        case ($urandom_range(0, 3))
            0:       t = jal_entry;
            default: t = reset_pc + (pc_t'($urandom_range(0, 255)) << 2);
        endcase
        return t;
    endfunction

    task automatic stall_for_unit(input logic is_div);
        int n;
        n = int'($urandom_range(1, 5));
        @(posedge clk);
        if (is_div) begin
            hold.div_wait <= 1'b1;
        end else begin
            hold.mul_wait <= 1'b1;
        end
        repeat (n) @(posedge clk);
        if (is_div) begin
            hold.div_done <= 1'b1;
        end else begin
            hold.mul_done <= 1'b1;
        end
        @(posedge clk);
        hold <= '0;
    endtask

    task automatic hold_memory();
        int n;
        n = int'($urandom_range(1, 6));
        @(posedge clk);
        hold.mem_hold <= 1'b1;
        repeat (n) @(posedge clk);
        hold <= '0;
    endtask

    task automatic issue_jalr();
        @(posedge clk);
        hold.jalr   <= 1'b1;
        hold.target <= random_target();
        @(posedge clk);
        hold.jalr <= 1'b0;     // Target stays for the load cycle
        @(posedge clk);
        hold <= '0;
    endtask

    task automatic send_redirect(input pc_t tgt);
        @(posedge clk);
        hold.redirect <= 1'b1;
        hold.target   <= tgt;
        @(posedge clk);
        hold <= '0;
    endtask

    // Redirect lands in the same cycle as the jal reply
    task automatic redirect_over_jal();
        send_redirect(jal_entry);
        @(posedge clk);
        while (!(mem_due && imem_addr == jal_entry)) begin
            @(posedge clk);
        end
        hold.redirect <= 1'b1;
        hold.target   <= random_target();
        @(posedge clk);
        hold <= '0;
    endtask

    initial begin
        int kind;
        void'($urandom(11));
        rst_n = 1'b0;
        hold  = '0;
        repeat (4) @(posedge clk);
        assert (!imem_req && !fo.valid && !hold_active && imem_addr == reset_pc)
            else log_error("outputs not in reset state");
        rst_n <= 1'b1;
        wait_fetches(free_fetches);
        for (int i = 0; i < hold_rounds; i++) begin
            kind = (i < 6) ? i : int'($urandom_range(0, 5));
            case (kind)
                0:       stall_for_unit(1'b0);
                1:       stall_for_unit(1'b1);
                2:       hold_memory();
                3:       issue_jalr();
                4:       send_redirect(random_target());
                default: redirect_over_jal();
            endcase
            wait_fetches(round_fetches);
        end
        $display("Run finished with %0d errors over %0d fetches", errors, fetch_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(planned_fetches * 40 * clk_period);
        $display("Watchdog expired: fetching stalled after %0d fetches", fetch_count);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== fetch_top.f ====
verilog/fetch_pkg.sv
verilog/hold_collect.sv
verilog/pc_predict.sv
verilog/fetch_port.sv
verilog/fetch_top.sv
dv/imem_model.sv
dv/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module tb_fetch_top -f fetch_top.f \
    -Mdir obj_dir -o tb_fetch_top > build.log 2>&1 \
    && ./obj_dir/tb_fetch_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "Test completed successfully" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen = 32;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;  // First fetch address

    localparam logic [6:0] op_jal = 7'b110_1111;

    typedef logic [xlen-1:0] pc_t;

    // Hold and redirect reasons from decode and execute
    typedef struct packed {
        logic mul_wait;   // Multiply sitting in decode
        logic mul_done;   // Multiplier finished
        logic div_wait;   // Divide sitting in decode
        logic div_done;   // Divider finished
        logic mem_hold;   // Memory hazard
        logic jalr;       // Jalr seen, target next cycle
        logic redirect;   // Level, target valid
        pc_t  target;
    } hold_req_t;

    typedef struct packed {
        logic hold;       // Any hold reason active
        logic freeze;     // Keep current PC
        logic load;       // Take load_pc
        pc_t  load_pc;
    } pc_ctl_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // J-type immediate is scattered over the upper 20 bits
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_view_t;

    typedef union packed {
        i_view_t i_view;
        j_view_t j_view;
    } instr_u;

    typedef struct packed {
        logic   valid;    // One cycle per returned word
        pc_t    pc;
        instr_u instr;
    } fetch_out_t;

endpackage

// ==== verilog/fetch_port.sv ====
module fetch_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::pc_t         pc,
    input  logic                   fetch_en,
    input  fetch_pkg::pc_ctl_t     ctl,
    output logic                   imem_req,
    output fetch_pkg::pc_t         imem_addr,
    input  logic [fetch_pkg::xlen-1:0] imem_rdata,
    input  logic                   imem_done,
    output logic                   done,
    output logic                   jal_hit,
    output fetch_pkg::pc_t         jal_pc,
    output fetch_pkg::fetch_out_t  fo
);

    import fetch_pkg::*;

    instr_u word;         // Returned word in both views
    logic   is_jal;
    pc_t    j_imm;

    logic   valid_q;
    pc_t    pc_q;
    instr_u instr_q;

    // PC moves only on done or hold so the address holds through a request
    assign imem_req  = fetch_en & ~ctl.hold;
    assign imem_addr = pc;
    assign done      = imem_done;

    assign word = instr_u'(imem_rdata);

    // Opcode sits in the same bits for both views
    assign is_jal = (word.i_view.opcode == op_jal);

    assign j_imm = {{11{word.j_view.imm_20}},
                    word.j_view.imm_20,
                    word.j_view.imm_19_12,
                    word.j_view.imm_11,
                    word.j_view.imm_10_1,
                    1'b0};

    assign jal_hit = imem_done & is_jal;
    assign jal_pc  = pc + j_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= imem_done;  // One pulse per word
        end
    end

    // Word and the PC it came from
    always_ff @(posedge clk) begin
        if (imem_done) begin
            pc_q    <= pc;
            instr_q <= word;
        end
    end

    // Decode reads fo.instr.i_view for rd, rs1, funct3 and imm
    assign fo = '{valid: valid_q, pc: pc_q, instr: instr_q};

endmodule

// ==== verilog/fetch_top.sv ====
module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fetch_pkg::hold_req_t       hold,
    output logic                       imem_req,
    output fetch_pkg::pc_t             imem_addr,
    input  logic [fetch_pkg::xlen-1:0] imem_rdata,
    input  logic                       imem_done,
    output fetch_pkg::fetch_out_t      fo,
    output logic                       hold_active
);

    import fetch_pkg::*;

    pc_ctl_t ctl;
    pc_t     pc;
    logic    fetch_en;
    logic    done;
    logic    jal_hit;
    pc_t     jal_pc;

    hold_collect u_hold_collect (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (hold),
        .ctl   (ctl)
    );

    pc_predict u_pc_predict (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .done     (done),
        .jal_hit  (jal_hit),
        .jal_pc   (jal_pc),
        .pc       (pc),
        .fetch_en (fetch_en)
    );

    fetch_port u_fetch_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .fetch_en   (fetch_en),
        .ctl        (ctl),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_done  (imem_done),
        .done       (done),
        .jal_hit    (jal_hit),
        .jal_pc     (jal_pc),
        .fo         (fo)
    );

    assign hold_active = ctl.hold;

endmodule

// ==== verilog/hold_collect.sv ====
module hold_collect (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::hold_req_t hold,
    output fetch_pkg::pc_ctl_t   ctl
);

    import fetch_pkg::*;

    logic jalr_d;     // Jalr seen last cycle
    logic any_wait;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_d <= 1'b0;
        end else begin
            jalr_d <= hold.jalr;
        end
    end

    assign any_wait = hold.mul_wait | hold.div_wait;

    // Fixed priority, highest first
    always_comb begin
        ctl.hold    = any_wait | hold.mem_hold | hold.jalr | jalr_d | hold.redirect;
        ctl.freeze  = 1'b0;
        ctl.load    = 1'b0;
        ctl.load_pc = hold.target;

        if (hold.mul_wait) begin
            ctl.freeze = ~hold.mul_done;  // Step once multiply is done
        end else if (hold.div_wait) begin
            ctl.freeze = ~hold.div_done;
        end else if (hold.mem_hold) begin
            ctl.freeze = 1'b1;
        end else if (hold.jalr) begin
            ctl.freeze = 1'b1;            // Target arrives a cycle later
        end else if (jalr_d) begin
            ctl.load = 1'b1;
        end else if (hold.redirect) begin
            ctl.load = 1'b1;
        end
    end

endmodule

// ==== verilog/pc_predict.sv ====
module pc_predict (
    input  logic               clk,
    input  logic               rst_n,
    input  fetch_pkg::pc_ctl_t ctl,
    input  logic               done,
    input  logic               jal_hit,
    input  fetch_pkg::pc_t     jal_pc,
    output fetch_pkg::pc_t     pc,
    output logic               fetch_en
);

    import fetch_pkg::*;

    pc_t  pc_plus4;
    pc_t  pc_next;
    logic update;

    // Fetch starts on the first clock after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    assign pc_plus4 = pc + pc_t'(4);

    // PC moves only when a word came back or some hold is active
    assign update = done | ctl.hold;

    always_comb begin
        if (ctl.freeze) begin
            pc_next = pc;
        end else if (ctl.load) begin
            pc_next = ctl.load_pc;   // Redirect wins over prediction
        end else if (jal_hit) begin
            pc_next = jal_pc;        // Static jal prediction
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (update) begin
            pc <= pc_next;
        end
    end

endmodule
